//--- src/fetch_pkg.sv
package fetch_pkg;

    // address and instruction sizes
    localparam int ADDR_W = 32;
    localparam int INST_W = 32;

    // one memory block holds two instructions
    localparam int BLOCK_W = 64;
    localparam int OFFSET_W = 3;

    // delivery width toward the instruction buffer
    localparam int FETCH_WIDTH = 4;
    // holds 0 to FETCH_WIDTH
    localparam int COUNT_W = $clog2(FETCH_WIDTH + 1);

    // current block plus the next two
    localparam int LOOKAHEAD = 3;

    // direct-mapped cache geometry
    localparam int CACHE_LINES = 32;
    localparam int INDEX_W = $clog2(CACHE_LINES);
    // address bits above index and offset
    localparam int CACHE_TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    // memory transaction tags, tag 0 is reserved
    localparam int NUM_TAGS = 15;
    localparam int TAG_W = 4;

    // instruction buffer
    localparam int IBUF_DEPTH = 16;
    // holds 0 to IBUF_DEPTH
    localparam int OPEN_W = $clog2(IBUF_DEPTH + 1);

    // memory writes the block whole, fetch picks single words
    // word 0 sits at the lower address
    typedef union packed {
        logic [BLOCK_W-1:0]         dword;
        logic [1:0][INST_W-1:0]     words;
    } mem_block_t;

endpackage

//--- src/icache_mem.sv
`timescale 1ns/100ps

module icache_mem import fetch_pkg::*; (
    input  logic                                clock,
    input  logic                                reset,
    // three consecutive block addresses
    input  logic [LOOKAHEAD-1:0][ADDR_W-1:0]    look_addr,
    // fill from a memory return
    input  logic                                fill_en,
    input  logic [ADDR_W-1:0]                   fill_addr,
    input  mem_block_t                          fill_data,
    output mem_block_t [LOOKAHEAD-1:0]          look_data,
    output logic [LOOKAHEAD-1:0]                look_hit
);

    // storage arrays
    mem_block_t                 line_data [CACHE_LINES];
    logic [CACHE_TAG_W-1:0]     line_tag  [CACHE_LINES];
    logic [CACHE_LINES-1:0]     line_valid;

    logic [INDEX_W-1:0]         fill_index;

    assign fill_index = fill_addr[OFFSET_W +: INDEX_W];

    // lookup, purely combinational
    always_comb begin
        for (int i = 0; i < LOOKAHEAD; i++) begin
            // index is bits 7:3
            look_data[i] = line_data[look_addr[i][OFFSET_W +: INDEX_W]];
            // tag compare against bits 31:8
            look_hit[i] = line_valid[look_addr[i][OFFSET_W +: INDEX_W]] &&
                (line_tag[look_addr[i][OFFSET_W +: INDEX_W]] ==
                 look_addr[i][ADDR_W-1 -: CACHE_TAG_W]);
        end
    end

    // valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_en) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    // data and tag written as one on a fill
    // visible to lookup the cycle after
    always_ff @(posedge clock) begin
        if (fill_en) begin
            line_data[fill_index] <= fill_data;
            line_tag[fill_index]  <= fill_addr[ADDR_W-1 -: CACHE_TAG_W];
        end
    end

endmodule

//--- src/miss_tracker.sv
`timescale 1ns/100ps

module miss_tracker import fetch_pkg::*; (
    input  logic                                clock,
    input  logic                                reset,
    // memory may be used this cycle
    input  logic                                grant,
    input  logic [LOOKAHEAD-1:0][ADDR_W-1:0]    look_addr,
    input  logic [LOOKAHEAD-1:0]                look_hit,
    // tag offered now, 0 means refused
    input  logic [TAG_W-1:0]                    mem_tag,
    // returned block, tag 0 means no data
    input  logic [TAG_W-1:0]                    mem_data_tag,
    input  mem_block_t                          mem_data,
    output logic                                mem_en,
    output logic [ADDR_W-1:0]                   mem_addr,
    output logic                                fill_en,
    output logic [ADDR_W-1:0]                   fill_addr,
    output mem_block_t                          fill_data
);

    // one entry per tag
    // slot 0 stays empty, memory never hands out tag 0
    logic [NUM_TAGS:0][ADDR_W-OFFSET_W-1:0]     entry_block;
    logic [NUM_TAGS:0]                          entry_valid;

    // lookahead block already outstanding
    logic [LOOKAHEAD-1:0]                       pending;
    logic                                       req_found;
    logic [ADDR_W-OFFSET_W-1:0]                 req_block;
    logic                                       accept;

    // match each lookahead block against the table
    always_comb begin
        pending = '0;
        for (int i = 0; i < LOOKAHEAD; i++) begin
            for (int j = 1; j <= NUM_TAGS; j++) begin
                if (entry_valid[j] &&
                    entry_block[j] == look_addr[i][ADDR_W-1:OFFSET_W]) begin
                    pending[i] = 1'b1;
                end
            end
        end
    end

    // first block missing in both cache and table
    always_comb begin
        req_found = 1'b0;
        req_block = '0;
        for (int i = 0; i < LOOKAHEAD; i++) begin
            if (!req_found && !look_hit[i] && !pending[i]) begin
                req_found = 1'b1;
                req_block = look_addr[i][ADDR_W-1:OFFSET_W];
            end
        end
    end

    // request goes out in the same cycle, block aligned
    assign mem_en   = grant && req_found;
    assign mem_addr = {req_block, {OFFSET_W{1'b0}}};
    // refused with tag 0, so retry later
    assign accept   = mem_en && (mem_tag != '0);

    // return of an outstanding tag turns into a fill
    // stray tags fall through
    assign fill_en   = (mem_data_tag != '0) && entry_valid[mem_data_tag];
    assign fill_addr = {entry_block[mem_data_tag], {OFFSET_W{1'b0}}};
    assign fill_data = mem_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else begin
            // free first, a new issue on the same tag wins
            if (fill_en) begin
                entry_valid[mem_data_tag] <= 1'b0;
            end
            if (accept) begin
                entry_valid[mem_tag] <= 1'b1;
            end
        end
    end

    // block addresses only matter while valid
    always_ff @(posedge clock) begin
        if (accept) begin
            entry_block[mem_tag] <= req_block;
        end
    end

endmodule

//--- src/inst_align.sv
`timescale 1ns/100ps

module inst_align import fetch_pkg::*; (
    input  logic                                clock,
    input  logic                                reset,
    // redirect
    input  logic                                squash,
    input  logic [ADDR_W-1:0]                   target,
    // free buffer entries
    input  logic [OPEN_W-1:0]                   ibuff_open,
    input  mem_block_t [LOOKAHEAD-1:0]          look_data,
    input  logic [LOOKAHEAD-1:0]                look_hit,
    output logic [LOOKAHEAD-1:0][ADDR_W-1:0]    look_addr,
    // registered instruction group
    output logic [FETCH_WIDTH-1:0][INST_W-1:0]  out_inst,
    output logic [FETCH_WIDTH-1:0][ADDR_W-1:0]  out_pc,
    output logic [COUNT_W-1:0]                  out_num_insts,
    output logic [ADDR_W-1:0]                   npc
);

    logic [ADDR_W-1:0]                      block_base;
    // instructions available through the leading hit run
    logic [COUNT_W-1:0]                     avail;
    logic                                   run_open;
    // buffer space left after the last group
    logic [OPEN_W-1:0]                      room;
    logic [COUNT_W-1:0]                     num_next;
    logic [FETCH_WIDTH-1:0][INST_W-1:0]     inst_next;
    logic [FETCH_WIDTH-1:0][ADDR_W-1:0]     pc_next;
    logic [ADDR_W-1:0]                      npc_next;

    // npc's block and the next two
    assign block_base = {npc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    always_comb begin
        for (int i = 0; i < LOOKAHEAD; i++) begin
            look_addr[i] = block_base + ADDR_W'(i * 8);
        end
    end

    // count through the hit run
    always_comb begin
        avail = '0;
        run_open = 1'b1;
        for (int i = 0; i < LOOKAHEAD; i++) begin
            if (run_open && look_hit[i]) begin
                // entered at the odd word, only one left
                if (i == 0 && npc[2]) begin
                    avail = avail + COUNT_W'(1);
                end else begin
                    avail = avail + COUNT_W'(2);
                end
            end else begin
                run_open = 1'b0;
            end
        end
    end

    // ibuff_open still counts the group on the outputs
    assign room = (ibuff_open > OPEN_W'(out_num_insts)) ?
                  ibuff_open - OPEN_W'(out_num_insts) : '0;

    // clamp by width, then by room
    always_comb begin
        num_next = avail;
        if (num_next > COUNT_W'(FETCH_WIDTH)) begin
            num_next = COUNT_W'(FETCH_WIDTH);
        end
        if (OPEN_W'(num_next) > room) begin
            num_next = COUNT_W'(room);
        end
    end

    // word k sits at offset npc[2] + k from block_base
    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            inst_next[k] = '0;
            pc_next[k]   = '0;
            if (COUNT_W'(k) < num_next) begin
                inst_next[k] = look_data[(k + int'(npc[2])) / 2].words[(k + int'(npc[2])) % 2];
                pc_next[k]   = npc + ADDR_W'(k * 4);
            end
        end
    end

    // sequential only, four bytes per instruction
    assign npc_next = npc + ADDR_W'({num_next, 2'b00});

    always_ff @(posedge clock) begin
        if (reset) begin
            out_inst      <= '0;
            out_pc        <= '0;
            out_num_insts <= '0;
            npc           <= '0;
        end else if (squash) begin
            // drop the old path, restart at target
            out_inst      <= '0;
            out_pc        <= '0;
            out_num_insts <= '0;
            npc           <= target;
        end else begin
            out_inst      <= inst_next;
            out_pc        <= pc_next;
            out_num_insts <= num_next;
            npc           <= npc_next;
        end
    end

endmodule

//--- src/fetch_top.sv
`timescale 1ns/100ps

module fetch_top import fetch_pkg::*; (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                squash,
    input  logic [ADDR_W-1:0]                   target,
    input  logic [OPEN_W-1:0]                   ibuff_open,
    // memory side
    input  logic                                grant,
    input  logic [TAG_W-1:0]                    mem_tag,
    input  logic [TAG_W-1:0]                    mem_data_tag,
    input  mem_block_t                          mem_data,
    output logic                                mem_en,
    output logic [ADDR_W-1:0]                   mem_addr,
    // toward the instruction buffer
    output logic [FETCH_WIDTH-1:0][INST_W-1:0]  out_inst,
    output logic [FETCH_WIDTH-1:0][ADDR_W-1:0]  out_pc,
    output logic [COUNT_W-1:0]                  out_num_insts,
    output logic [ADDR_W-1:0]                   npc
);

    // lookahead path
    logic [LOOKAHEAD-1:0][ADDR_W-1:0]   look_addr;
    mem_block_t [LOOKAHEAD-1:0]         look_data;
    logic [LOOKAHEAD-1:0]               look_hit;

    // fill path
    logic                               fill_en;
    logic [ADDR_W-1:0]                  fill_addr;
    mem_block_t                         fill_data;

    icache_mem u_icache_mem (
        .clock          (clock),
        .reset          (reset),
        .look_addr      (look_addr),
        .fill_en        (fill_en),
        .fill_addr      (fill_addr),
        .fill_data      (fill_data),
        .look_data      (look_data),
        .look_hit       (look_hit)
    );

    miss_tracker u_miss_tracker (
        .clock          (clock),
        .reset          (reset),
        .grant          (grant),
        .look_addr      (look_addr),
        .look_hit       (look_hit),
        .mem_tag        (mem_tag),
        .mem_data_tag   (mem_data_tag),
        .mem_data       (mem_data),
        .mem_en         (mem_en),
        .mem_addr       (mem_addr),
        .fill_en        (fill_en),
        .fill_addr      (fill_addr),
        .fill_data      (fill_data)
    );

    inst_align u_inst_align (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .target         (target),
        .ibuff_open     (ibuff_open),
        .look_data      (look_data),
        .look_hit       (look_hit),
        .look_addr      (look_addr),
        .out_inst       (out_inst),
        .out_pc         (out_pc),
        .out_num_insts  (out_num_insts),
        .npc            (npc)
    );

endmodule

//--- test/mem_model.sv
`timescale 1ns/100ps

module mem_model import fetch_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    mem_en,
    input  logic [ADDR_W-1:0]       mem_addr,
    // 64 words, repeats every 256 bytes
    input  logic [INST_W-1:0]       image [64],
    output logic                    grant,
    output logic [TAG_W-1:0]        mem_tag,
    output logic [TAG_W-1:0]        mem_data_tag,
    output mem_block_t              mem_data,
    output int                      errors,
    output int                      refused,
    output int                      retried
);

    logic [31:0]                    lfsr_state = 32'h09476f64;
    // outstanding transactions, slot 0 unused
    logic [NUM_TAGS:0]              busy;
    logic [NUM_TAGS:0][ADDR_W-1:0]  slot_addr;
    int                             slot_wait [NUM_TAGS+1];
    // last refused block, waiting for its retry
    logic [ADDR_W-1:0]              refused_addr;
    logic                           refused_open;

    // galois lfsr, one step per bit taken
    function logic [7:0] take_bits(input int n);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[6:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hA3000000 : lfsr_state >> 1;
        end
        return bits;
    endfunction

    always @(posedge clock) begin
        mem_block_t         blk;
        int                 ret;
        logic [5:0]         idx;
        logic [TAG_W-1:0]   free_tag;
        if (reset) begin
            busy = '0;
            refused_open = 1'b0;
            errors = 0;
            refused = 0;
            retried = 0;
            grant <= 1'b0;
            mem_tag <= '0;
            mem_data_tag <= '0;
            mem_data <= '0;
        end else begin
            // countdown, then at most one return per cycle
            ret = 0;
            for (int t = 1; t <= NUM_TAGS; t++) begin
                if (busy[t]) begin
                    if (slot_wait[t] > 0) begin
                        slot_wait[t]--;
                    end else if (ret == 0) begin
                        ret = t;
                    end
                end
            end
            if (ret != 0) begin
                idx = slot_addr[ret][7:2];
                // written whole, lower word sits in the low half
                blk.dword = {image[{idx[5:1], 1'b1}], image[idx]};
                busy[ret] = 1'b0;
                mem_data_tag <= TAG_W'(ret);
                mem_data <= blk;
            end else begin
                mem_data_tag <= '0;
                mem_data <= '0;
            end
            // request seen at this edge
            if (mem_en) begin
                if (mem_addr[OFFSET_W-1:0] != '0) begin
                    $display("request to %h is not block aligned", mem_addr);
                    errors++;
                end
                for (int t = 1; t <= NUM_TAGS; t++) begin
                    if (busy[t] && slot_addr[t] == mem_addr) begin
                        $display("block %h requested again while outstanding", mem_addr);
                        errors++;
                    end
                end
                if (refused_open && mem_addr == refused_addr) begin
                    retried++;
                    refused_open = 1'b0;
                end
                if (mem_tag == '0) begin
                    refused++;
                    refused_addr = mem_addr;
                    refused_open = 1'b1;
                end else begin
                    busy[mem_tag] = 1'b1;
                    slot_addr[mem_tag] = mem_addr;
                    slot_wait[mem_tag] = int'(take_bits(3)) + 1;
                end
            end
            // next offer, lowest free tag
            free_tag = '0;
            for (int t = NUM_TAGS; t >= 1; t--) begin
                if (!busy[t]) free_tag = TAG_W'(t);
            end
            grant <= (take_bits(2) != 8'd0);
            mem_tag <= (take_bits(2) == 8'd0) ? '0 : free_tag;
        end
    end

endmodule

//--- test/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb import fetch_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int IMAGE_WORDS = 64;
    localparam int MAX_STEPS = 10;
    localparam int DATA_WORDS = IMAGE_WORDS + 3 * MAX_STEPS;
    localparam logic [31:0] NO_TARGET = 32'hffffffff;
    localparam int MARGIN = 100;

    logic                               clock;
    logic                               reset;
    logic                               squash;
    logic [ADDR_W-1:0]                  target;
    logic [OPEN_W-1:0]                  ibuff_open;
    logic                               grant;
    logic [TAG_W-1:0]                   mem_tag;
    logic [TAG_W-1:0]                   mem_data_tag;
    mem_block_t                         mem_data;
    logic                               mem_en;
    logic [ADDR_W-1:0]                  mem_addr;
    logic [FETCH_WIDTH-1:0][INST_W-1:0] out_inst;
    logic [FETCH_WIDTH-1:0][ADDR_W-1:0] out_pc;
    logic [COUNT_W-1:0]                 out_num_insts;
    logic [ADDR_W-1:0]                  npc;

    logic [31:0]                        testdata [DATA_WORDS];
    logic [INST_W-1:0]                  image [IMAGE_WORDS];
    int                                 errors = 0;
    int                                 mem_errors;
    int                                 refused;
    int                                 retried;
    int                                 delivered = 0;
    int                                 watch_cycles = 0;

    // reference model state
    logic [ADDR_W-1:0]                  exp_pc = '0;
    // inputs the DUT sees at the coming edge
    logic                               prev_squash = 1'b0;
    logic [ADDR_W-1:0]                  prev_target = '0;
    logic [OPEN_W-1:0]                  prev_open = '0;
    logic [COUNT_W-1:0]                 prev_count = '0;

    fetch_top DUT (.*);

    mem_model u_mem_model (
        .clock(clock), .reset(reset), .mem_en(mem_en), .mem_addr(mem_addr),
        .image(image), .grant(grant), .mem_tag(mem_tag), .mem_data_tag(mem_data_tag),
        .mem_data(mem_data), .errors(mem_errors), .refused(refused), .retried(retried)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task check_word(input string name, input logic [INST_W-1:0] got, input logic [INST_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task check_addr(input string name, input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task check_count(input string name, input logic [COUNT_W-1:0] got,
                     input logic [COUNT_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clock) begin
        int room;
        if (!reset) begin
            if (!grant && mem_en) begin
                $display("mem_en raised while grant was low");
                errors++;
            end
            if (prev_squash) begin
                // group cleared, stream restarts at target
                check_count("out_num_insts", out_num_insts, '0);
                exp_pc = prev_target;
            end else begin
                room = int'(prev_open) - int'(prev_count);
                if (room < 0) room = 0;
                if (int'(out_num_insts) > FETCH_WIDTH || int'(out_num_insts) > room) begin
                    $display("group of %0d exceeds the limit, room was %0d",
                             out_num_insts, room);
                    errors++;
                end
                for (int k = 0; k < int'(out_num_insts); k++) begin
                    check_addr($sformatf("out_pc[%0d]", k), out_pc[k], exp_pc);
                    check_word($sformatf("out_inst[%0d]", k), out_inst[k], image[exp_pc[7:2]]);
                    exp_pc = exp_pc + 32'd4;
                    delivered++;
                end
            end
            check_addr("npc", npc, exp_pc);
        end
        prev_squash = squash;
        prev_target = target;
        prev_open = ibuff_open;
        prev_count = out_num_insts;
    end

    initial begin
        int                 step;
        int                 total;
        int                 err_before;
        int                 del_before;
        logic [ADDR_W-1:0]  st_target;
        int                 st_open;
        int                 st_cycles;
        reset = 1'b1;
        squash = 1'b0;
        target = '0;
        ibuff_open = '0;
        for (int i = 0; i < DATA_WORDS; i++) testdata[i] = '0;
        $readmemh("test/fetch_testdata.txt", testdata);
        for (int i = 0; i < IMAGE_WORDS; i++) image[i] = testdata[i];
        // script length sets the watchdog
        total = 4;
        for (int s = 0; s < MAX_STEPS; s++) total += int'(testdata[IMAGE_WORDS + 3 * s + 2]) + 1;
        watch_cycles = total + MARGIN;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        err_before = errors;
        check_count("out_num_insts", out_num_insts, '0);
        check_addr("npc", npc, '0);
        $display("test 0 reset: %0d errors", errors - err_before);
        step = 0;
        while (step < MAX_STEPS && testdata[IMAGE_WORDS + 3 * step + 2] != '0) begin
            st_target = testdata[IMAGE_WORDS + 3 * step];
            st_open = int'(testdata[IMAGE_WORDS + 3 * step + 1]);
            st_cycles = int'(testdata[IMAGE_WORDS + 3 * step + 2]);
            err_before = errors + mem_errors;
            del_before = delivered;
            @(posedge clock);
            ibuff_open <= OPEN_W'(st_open);
            if (st_target != NO_TARGET) begin
                squash <= 1'b1;
                target <= st_target;
            end
            @(posedge clock);
            squash <= 1'b0;
            repeat (st_cycles - 1) @(posedge clock);
            $display("test %0d target %h open %0d: %0d insts, %0d errors", step + 1, st_target,
                     st_open, delivered - del_before, errors + mem_errors - err_before);
            step++;
        end
        @(negedge clock);
        // after the output checks of that falling edge
        #(CLK_PERIOD / 4);
        if (delivered == 0) begin
            $display("no instruction was delivered during the run");
            errors++;
        end
        if (refused > 0 && retried == 0) begin
            $display("no refused request was ever repeated");
            errors++;
        end
        $display("%0d insts, %0d refused, %0d retried, %0d errors, %0d memory errors",
                 delivered, refused, retried, errors, mem_errors);
        if (errors + mem_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (watch_cycles > 0);
        #(watch_cycles * CLK_PERIOD);
        $display("timeout, script did not end within %0d cycles", watch_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- test/fetch_testdata.txt
// words 0 to 63: memory image, word n holds the instruction at byte address 4*n
// then script steps of three words: target (ffffffff for none), ibuff_open, cycles
c0de0000 c0de0004 c0de0008 c0de000c c0de0010 c0de0014 c0de0018 c0de001c
c0de0020 c0de0024 c0de0028 c0de002c c0de0030 c0de0034 c0de0038 c0de003c
c0de0040 c0de0044 c0de0048 c0de004c c0de0050 c0de0054 c0de0058 c0de005c
c0de0060 c0de0064 c0de0068 c0de006c c0de0070 c0de0074 c0de0078 c0de007c
c0de0080 c0de0084 c0de0088 c0de008c c0de0090 c0de0094 c0de0098 c0de009c
c0de00a0 c0de00a4 c0de00a8 c0de00ac c0de00b0 c0de00b4 c0de00b8 c0de00bc
c0de00c0 c0de00c4 c0de00c8 c0de00cc c0de00d0 c0de00d4 c0de00d8 c0de00dc
c0de00e0 c0de00e4 c0de00e8 c0de00ec c0de00f0 c0de00f4 c0de00f8 c0de00fc
// script
ffffffff 00000010 00000028
00000044 00000010 0000001e
ffffffff 00000000 0000000a
ffffffff 00000006 00000014
000000a4 00000003 00000019
00000010 00000010 0000001e
000000fc 00000010 00000028
00000000 00000000 00000000

//--- vlog.f
src/fetch_pkg.sv
src/icache_mem.sv
src/miss_tracker.sv
src/inst_align.sv
src/fetch_top.sv
test/mem_model.sv
test/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FLIST     ?= vlog.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD)
